// File: jx2Fetch.f
+incdir+.
jx2FetchPkg.sv
jx2PcSequencer.sv
jx2IcTile.sv
jx2InstrPredecode.sv
jx2FetchTop.sv
jx2Fetch_properties.sv
jx2FetchTb.sv

// File: jx2FetchPkg.sv
// fetch front end types
// memory request, the two-way fetch word and the instruction packet

`include "jx2Fetch_defs.svh"

package jx2FetchPkg;

	typedef struct packed {
		logic [`FETCH_LINE_W-1:0] lineAddr;  // first line of block
		logic [`FETCH_ADDR_W-1:0] byteAddr;  // same line in bytes
		logic                     strobe;
	} memReq_t;

	// 16-bit instruction, upper halfword is not part of it
	typedef struct packed {
		logic [`FETCH_HALF_W-1:0] unused;
		logic [2:0]               lenTag;  // bits 15:13
		logic [4:0]               opHi;
		logic [3:0]               dstReg;  // bits 7:4
		logic [3:0]               opLo;
	} shortView_t;

	// 32-bit instruction, destination sits in the second halfword
	typedef struct packed {
		logic [11:0]              opHi;
		logic [3:0]               dstReg;  // bits 19:16
		logic [`FETCH_HALF_W-1:0] prefix;
	} longView_t;

	typedef union packed {
		shortView_t shortView;
		longView_t  longView;
	} fetchWord_u;

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
		fetchWord_u               word;
		logic                     is32;
		logic [3:0]               dstReg;
	} instrPacket_t;

endpackage

// File: jx2FetchTb.sv
// testbench for the instruction fetch front end
// random memory contents with random refill latency, a reference fetch
// model and in-order checks of every instruction packet

`timescale 1ns/1ps
`include "jx2Fetch_defs.svh"

module jx2FetchTb
	import jx2FetchPkg::*;
();

	localparam int RunLen       = 200;
	localparam int RestartAfter = 60;   // packets before the mid-stream restart
	localparam int NumInstr     = 3 * RunLen + RestartAfter;
	localparam int WorstRefill  = 10;   // strobe, 6 cycles latency, reload, slack
	localparam int MarginCycles = 200;

	logic                      clock = 1'b0;
	logic                      arstN;
	logic                      startStrobe;
	logic [`FETCH_ADDR_W-1:0]  startPc;
	logic [`FETCH_BLOCK_W-1:0] memData;
	logic                      memAck;
	memReq_t                   memRequest;
	logic                      instrValid;
	instrPacket_t              instr;

	int                        seed;
	logic [15:0]               memTable [0:4095];
	logic [2:0]                latTable [0:1023];   // refill latency per request
	logic [`FETCH_ADDR_W-1:0]  expPc;               // next PC of the model
	logic [`FETCH_ADDR_W-1:0]  newPc;
	logic                      flushing;            // old stream may still drain
	int                        gotCount;

	jx2FetchTop UUT (
		.clock       (clock),
		.arstN       (arstN),
		.startStrobe (startStrobe),
		.startPc     (startPc),
		.memData     (memData),
		.memAck      (memAck),
		.memRequest  (memRequest),
		.instrValid  (instrValid),
		.instr       (instr)
	);

	always #10 clock = ~clock;

	// memory halfword, table value mixed with the upper address bits
	function automatic logic [15:0] memHalf(input logic [18:0] halfAddr);
		return memTable[halfAddr[11:0]] ^ {9'd0, halfAddr[18:12]};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	initial
	begin : memoryModel
		logic [`FETCH_ADDR_W-1:0] reqByte;
		logic [9:0]               reqCount;
		int                       waitLeft;
		memAck   = 1'b0;
		memData  = '0;
		reqByte  = '0;
		reqCount = '0;
		waitLeft = 0;
		forever
		begin
			@(posedge clock);
			#2;
			memAck = 1'b0;
			if (waitLeft > 0)
			begin
				waitLeft--;
				if (waitLeft == 0)
				begin
					for (int i = 0; i < 16; i++)
						memData[i*16 +: 16] = memHalf(reqByte[19:1] + 19'(i));
					memAck = 1'b1;
				end
			end
			else if (memRequest.strobe)
			begin
				reqByte  = memRequest.byteAddr;
				waitLeft = int'(latTable[reqCount]);
				reqCount = reqCount + 10'd1;
			end
		end
	end

	// one cycle of the reference model, sampled after the drive point
	task automatic observeCycle();
		logic [15:0] h0;
		logic [15:0] h1;
		logic        exp32;
		@(posedge clock);
		#2;
		if (instrValid && !(flushing && instr.pc != newPc))
		begin
			flushing = 1'b0;
			h0 = memHalf(expPc[19:1]);
			h1 = memHalf(expPc[19:1] + 19'd1);
			exp32 = &h0[15:13];  // long form tag
			checkValue("instr.pc", 64'(expPc), 64'(instr.pc));
			checkValue("instr.word", 64'({h1, h0}), 64'(instr.word));
			checkValue("instr.is32", 64'(exp32), 64'(instr.is32));
			checkValue("instr.dstReg", 64'(exp32 ? h1[3:0] : h0[7:4]), 64'(instr.dstReg));
			expPc = expPc + (exp32 ? 20'd4 : 20'd2);
			gotCount++;
		end
		// a strobe in the cycle of the start edge still belongs to the old stream
		if (memRequest.strobe && !startStrobe)
		begin
			checkValue("memRequest.lineAddr", 64'(expPc[19:4]),
				64'(memRequest.lineAddr));
			checkValue("memRequest.byteAddr", 64'({expPc[19:4], 4'h0}),
				64'(memRequest.byteAddr));
		end
	endtask

	task automatic runStream(input logic [`FETCH_ADDR_W-1:0] pcStart, input int count);
		startPc     = pcStart;
		startStrobe = 1'b1;
		newPc       = {pcStart[19:1], 1'b0};
		expPc       = newPc;
		flushing    = 1'b1;
		gotCount    = 0;
		observeCycle();
		startStrobe = 1'b0;
		while (gotCount < count)
			observeCycle();
	endtask

	initial
	begin
		logic [`FETCH_ADDR_W-1:0] pcA;
		seed        = 94664;
		arstN       = 1'b0;
		startStrobe = 1'b0;
		startPc     = '0;
		expPc       = '0;
		newPc       = '0;
		flushing    = 1'b0;
		gotCount    = 0;
		for (int i = 0; i < 4096; i++)
			memTable[i] = 16'($random(seed));
		for (int i = 0; i < 1024; i++)
			latTable[i] = 3'(1 + ($unsigned($random(seed)) % 6));
		pcA = 20'($random(seed));
		repeat (3) @(posedge clock);
		#2;
		arstN = 1'b1;
		repeat (8)  // idle until the first start
		begin
			@(posedge clock);
			#2;
			checkValue("instrValid", 64'd0, 64'(instrValid));
			checkValue("memRequest.strobe", 64'd0, 64'(memRequest.strobe));
		end
		runStream(pcA, RunLen);
		runStream(20'($random(seed)), RestartAfter);
		runStream(20'($random(seed)), RunLen);  // restart in mid-stream
		runStream(pcA, RunLen);  // same start, later refill latencies
		if (UUT.props.failCount != 0)
		begin
			$display("assertion failures were counted on the memory or instruction strobes");
			$display("Something failed");
			$fatal(1);
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

	initial
	begin
		#((NumInstr * WorstRefill + MarginCycles) * 20);
		$display("Timeout: the instruction stream stopped before all runs finished");
		$display("Something failed");
		$fatal(1);
	end

endmodule

// File: jx2FetchTop.sv
// instruction fetch front end
// PC sequencer, single-block cache tile and predecoder wired to the
// memory port and the instruction output

`timescale 1ns/1ps
`include "jx2Fetch_defs.svh"

module jx2FetchTop
	import jx2FetchPkg::*;
(
	input  logic                      clock,
	input  logic                      arstN,
	input  logic                      startStrobe,
	input  logic [`FETCH_ADDR_W-1:0]  startPc,
	input  logic [`FETCH_BLOCK_W-1:0] memData,
	input  logic                      memAck,
	output memReq_t                   memRequest,
	output logic                      instrValid,
	output instrPacket_t              instr
);

	logic [`FETCH_ADDR_W-1:0] pc;
	logic                     running;
	logic                     hit;
	logic                     is32;
	fetchWord_u               fetchWord;

	jx2PcSequencer sequencer (
		.clock       (clock),
		.arstN       (arstN),
		.startStrobe (startStrobe),
		.startPc     (startPc),
		.hit         (hit),
		.is32        (is32),
		.pc          (pc),
		.running     (running)
	);

	jx2IcTile tile (
		.clock      (clock),
		.arstN      (arstN),
		.pc         (pc),
		.running    (running),
		.memData    (memData),
		.memAck     (memAck),
		.memRequest (memRequest),
		.fetchWord  (fetchWord),
		.hit        (hit)
	);

	jx2InstrPredecode predecode (
		.clock      (clock),
		.arstN      (arstN),
		.pc         (pc),
		.fetchWord  (fetchWord),
		.hit        (hit),
		.running    (running),
		.is32       (is32),
		.instrValid (instrValid),
		.instr      (instr)
	);

endmodule

// File: jx2Fetch_defs.svh
// fetch front end width definitions
// address, line, block and halfword widths fixed by the instruction set

`ifndef JX2FETCH_DEFS_SVH
`define JX2FETCH_DEFS_SVH

// byte address of the fetch PC
`define FETCH_ADDR_W 20

// line index, one line is 16 bytes
`define FETCH_LINE_W 16

// one cache block holds two adjacent lines
`define FETCH_BLOCK_W 256

// instructions are built from 16-bit halfwords
`define FETCH_HALF_W 16

`endif

// File: jx2Fetch_properties.sv
// strobe properties of the fetch front end
// single-cycle request strobes, one refill in flight, known instrValid

`timescale 1ns/1ps

module jx2FetchProperties
	import jx2FetchPkg::*;
(
	input logic    clock,
	input logic    arstN,
	input memReq_t memRequest,
	input logic    memAck,
	input logic    instrValid
);

	logic outstanding;    // request sent, no acknowledge yet
	int   failCount = 0;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			outstanding <= 1'b0;
		else if (memAck)
			outstanding <= 1'b0;
		else if (memRequest.strobe)
			outstanding <= 1'b1;
	end

	strobeSingle: assert property (@(posedge clock) disable iff (!arstN)
		memRequest.strobe |=> !memRequest.strobe)
	else
	begin
		failCount++;
		$error("request strobe high in two consecutive cycles");
	end

	oneInFlight: assert property (@(posedge clock) disable iff (!arstN)
		outstanding |-> !memRequest.strobe)
	else
	begin
		failCount++;
		$error("request issued before the previous one was acknowledged");
	end

	validKnown: assert property (@(posedge clock) disable iff (!arstN)
		!$isunknown(instrValid))
	else
	begin
		failCount++;
		$error("instrValid is unknown after reset");
	end

endmodule

bind jx2FetchTop jx2FetchProperties props (.*);

// File: jx2IcTile.sv
// single-block instruction cache tile
// keeps one 256-bit block (two adjacent 16-byte lines) and serves the
// 32-bit window starting at the PC's halfword; refills on a miss

`timescale 1ns/1ps
`include "jx2Fetch_defs.svh"

module jx2IcTile
	import jx2FetchPkg::*;
(
	input  logic                      clock,
	input  logic                      arstN,
	input  logic [`FETCH_ADDR_W-1:0]  pc,
	input  logic                      running,
	input  logic [`FETCH_BLOCK_W-1:0] memData,
	input  logic                      memAck,
	output memReq_t                   memRequest,
	output fetchWord_u                fetchWord,
	output logic                      hit
);

	localparam int PadW = `FETCH_BLOCK_W + `FETCH_HALF_W;

	logic [`FETCH_BLOCK_W-1:0] blkData;   // cached block, lower line first
	logic [`FETCH_LINE_W-1:0]  blkLine;   // line of the lower half
	logic                      blkValid;
	logic [`FETCH_LINE_W-1:0]  reqLine;   // line of the outstanding request
	logic                      reqStrobe;
	logic                      pending;   // waiting for memAck

	logic [`FETCH_LINE_W-1:0]  pcLine;
	logic [`FETCH_LINE_W-1:0]  nextLine;
	logic                      lineMatch;
	logic                      blkHi;     // PC is in the upper line
	logic [3:0]                halfIx;    // halfword within the block
	logic [PadW-1:0]           padData;
	logic                      issue;

	assign pcLine    = pc[`FETCH_ADDR_W-1:`FETCH_ADDR_W-`FETCH_LINE_W];
	assign nextLine  = blkLine + 1'b1;
	assign blkHi     = (pcLine != blkLine);
	assign lineMatch = (pcLine == blkLine) || (pcLine == nextLine);
	assign halfIx    = {blkHi, pc[3:1]};

	// last halfword counts as a miss so a long instruction never
	// runs off the end of the block
	assign hit = blkValid && lineMatch && (halfIx != 4'hf);

	// zero pad so the window at index 15 stays in range
	assign padData   = {{`FETCH_HALF_W{1'b0}}, blkData};
	assign fetchWord = padData[{halfIx, 4'b0000} +: 32];

	// one request per miss, none while a refill is in flight
	assign issue = running && !hit && !pending;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			reqStrobe <= 1'b0;
			pending   <= 1'b0;
			blkValid  <= 1'b0;
		end
		else
		begin
			reqStrobe <= issue;
			if (memAck)
				pending <= 1'b0;
			else if (issue)
				pending <= 1'b1;
			if (memAck)
				blkValid <= 1'b1;  // stays set, only the contents change
		end
	end

	always_ff @(posedge clock)
	begin
		if (issue)
			reqLine <= pcLine;  // block starts at the missing line
		if (memAck)
		begin
			blkData <= memData;
			blkLine <= reqLine;
		end
	end

	always_comb
	begin
		memRequest.lineAddr = reqLine;
		memRequest.byteAddr = {reqLine, {(`FETCH_ADDR_W-`FETCH_LINE_W){1'b0}}};
		memRequest.strobe   = reqStrobe;
	end

endmodule

// File: jx2InstrPredecode.sv
// instruction predecoder
// sorts the fetched word into 16-bit or 32-bit form, picks out the
// destination register and registers one packet per hit

`timescale 1ns/1ps
`include "jx2Fetch_defs.svh"

module jx2InstrPredecode
	import jx2FetchPkg::*;
(
	input  logic                     clock,
	input  logic                     arstN,
	input  logic [`FETCH_ADDR_W-1:0] pc,
	input  fetchWord_u               fetchWord,
	input  logic                     hit,
	input  logic                     running,
	output logic                     is32,
	output logic                     instrValid,
	output instrPacket_t             instr
);

	logic [3:0] dstReg;
	logic       take;

	// long form when the top three bits of the first halfword are set
	assign is32 = &fetchWord.shortView.lenTag;

	assign dstReg = is32 ? fetchWord.longView.dstReg
	                     : fetchWord.shortView.dstReg;

	assign take = hit && running;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			instrValid <= 1'b0;
		else
			instrValid <= take;  // one strobe per hit cycle
	end

	always_ff @(posedge clock)
	begin
		if (take)
		begin
			instr.pc     <= pc;
			instr.word   <= fetchWord;
			instr.is32   <= is32;
			instr.dstReg <= dstReg;
		end
	end

endmodule

// File: jx2PcSequencer.sv
// PC sequencer
// loads the PC on a start strobe and steps it by the instruction
// length on every cache hit while running

`timescale 1ns/1ps
`include "jx2Fetch_defs.svh"

module jx2PcSequencer
(
	input  logic                     clock,
	input  logic                     arstN,
	input  logic                     startStrobe,
	input  logic [`FETCH_ADDR_W-1:0] startPc,
	input  logic                     hit,
	input  logic                     is32,
	output logic [`FETCH_ADDR_W-1:0] pc,
	output logic                     running
);

	logic [`FETCH_ADDR_W-1:0] step;

	assign step = is32 ? `FETCH_ADDR_W'd4 : `FETCH_ADDR_W'd2;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pc      <= '0;
			running <= 1'b0;
		end
		else if (startStrobe)
		begin
			// restart wins over a step in the same cycle
			pc      <= {startPc[`FETCH_ADDR_W-1:1], 1'b0};
			running <= 1'b1;
		end
		else if (running && hit)
		begin
			pc <= pc + step;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module jx2FetchTb -f jx2Fetch.f -o jx2FetchSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/jx2FetchSim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "FAIL: simulator exited with status $status"
	exit 1
fi
echo "PASS"
exit 0
